//--- hw/eth_dma_pkg.sv
package eth_dma_pkg;

   localparam int DATA_W        = 32;
   localparam int LEN_W         = 10;
   localparam int AXI_ADDR_MAX  = 32;
   localparam int BUF_ADDR_MAX  = 9;
   localparam int TX_DATA_BASE  = 5;     // words below this hold preamble and header
   localparam int MAX_FRAME_LEN = 1020;

   localparam logic [2:0] AR_SIZE_WORD  = 3'd2;
   localparam logic [1:0] AR_BURST_INCR = 2'd1;
   localparam logic [3:0] AR_CACHE      = 4'd2;
   localparam logic [2:0] AR_PROT       = 3'd2;

   typedef struct packed {
      logic [AXI_ADDR_MAX-1:0] addr;
      logic [7:0]              len;
      logic [2:0]              size;
      logic [1:0]              burst;
   } axi_ar_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [1:0]        resp;
      logic              last;
   } axi_r_t;

   typedef struct packed {
      logic [AXI_ADDR_MAX-1:0] addr;
      logic [LEN_W-1:0]        len;
   } dma_cfg_t;

   // ready is bit 1, done is bit 0 of REG_STATUS
   typedef struct packed {
      logic ready;
      logic done;
   } dma_status_t;

   typedef struct packed {
      logic                    wr;
      logic [BUF_ADDR_MAX-1:0] addr;
      logic [DATA_W-1:0]       data;
   } buf_wr_t;

   typedef enum logic [2:0] {IDLE, ADDR, DATA, FLUSH, FINISH} dma_state_e;

   typedef enum logic [1:0] {REG_ADDR, REG_LEN, REG_CTRL, REG_STATUS} cfg_reg_e;

endpackage

//--- hw/eth_dma_regs.sv
`timescale 1ns/1ps

module eth_dma_regs #(
   parameter int AXI_ADDR_W = 32
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    cfg_wr,
   input  logic                    cfg_rd,
   input  eth_dma_pkg::cfg_reg_e   cfg_sel,
   input  logic [31:0]             cfg_wdata,
   output logic [31:0]             cfg_rdata,
   output eth_dma_pkg::dma_cfg_t   cfg,
   output logic                    run,
   input  logic                    ready
);
   import eth_dma_pkg::*;

   logic [AXI_ADDR_W-1:0] addr_q;
   logic [LEN_W-1:0]      len_q;
   logic                  done;
   logic                  ready_q;
   logic                  run_req;
   dma_status_t           status;

   assign run_req = cfg_wr && (cfg_sel == REG_CTRL) && cfg_wdata[0];

   assign cfg    = '{addr: AXI_ADDR_MAX'(addr_q), len: len_q};
   assign status = '{ready: ready, done: done};

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         addr_q    <= '0;
         len_q     <= '0;
         run       <= 1'b0;
         done      <= 1'b0;
         ready_q   <= 1'b1;
         cfg_rdata <= '0;
      end else begin
         ready_q <= ready;
         // engine drops ready a cycle after run, so block a second run meanwhile
         run <= run_req & ready & ~run;

         if (cfg_wr && cfg_sel == REG_ADDR)
            addr_q <= cfg_wdata[AXI_ADDR_W-1:0];
         if (cfg_wr && cfg_sel == REG_LEN)
            len_q <= cfg_wdata[LEN_W-1:0];

         if (run)
            done <= 1'b0;
         else if (ready && !ready_q)
            done <= 1'b1;        // sticky until next run

         if (cfg_rd) begin
            case (cfg_sel)
               REG_ADDR:   cfg_rdata <= 32'(addr_q);
               REG_LEN:    cfg_rdata <= 32'(len_q);
               REG_CTRL:   cfg_rdata <= {31'd0, ~ready};   // busy
               REG_STATUS: cfg_rdata <= 32'(status);
               default:    cfg_rdata <= '0;
            endcase
         end
      end
   end

   // engine must still be idle when the gated run arrives
   run_only_when_ready: assert property (
      @(posedge clk) disable iff (rst) run |-> ready
   );

endmodule

//--- hw/eth_burst_align.sv
`timescale 1ns/1ps

module eth_burst_align (
   input  logic                             clk,
   input  logic                             rst,
   input  logic [eth_dma_pkg::DATA_W-1:0]   data,
   input  logic                             transfer,
   input  logic                             flush,
   input  logic [1:0]                       offset,
   input  logic [eth_dma_pkg::LEN_W-1:0]    len,
   output logic [7:0]                       burst_len,
   output logic [eth_dma_pkg::DATA_W-1:0]   data_out,
   output logic                             first_valid
);
   import eth_dma_pkg::*;

   logic [DATA_W-1:0] prev;
   logic [LEN_W:0]    span;

   // lo supplies bytes from off upward, hi fills the top
   function automatic logic [DATA_W-1:0] realign(
      input logic [DATA_W-1:0] lo,
      input logic [DATA_W-1:0] hi,
      input logic [1:0]        off
   );
      logic [DATA_W-1:0] word;
      case (off)
         2'd1:    word = {hi[7:0], lo[DATA_W-1:8]};
         2'd2:    word = {hi[15:0], lo[DATA_W-1:16]};
         2'd3:    word = {hi[23:0], lo[DATA_W-1:24]};
         default: word = hi;
      endcase
      return word;
   endfunction

   // beats = ceil((offset + len) / 4)
   assign span      = (LEN_W+1)'(len) + (LEN_W+1)'(offset) + (LEN_W+1)'(3);
   assign burst_len = 8'(span[LEN_W:2] - 1'b1);

   // with no offset every beat is already a frame word
   assign first_valid = (offset == 2'd0);

   always_ff @(posedge clk) begin
      if (transfer) begin
         prev     <= data;
         data_out <= realign(prev, data, offset);
      end else if (flush) begin
         data_out <= realign(prev, '0, offset);   // tail of the last beat
      end
   end

   // register block length must stay within the buffer area
   len_in_range: assert property (
      @(posedge clk) disable iff (rst) transfer |-> len <= MAX_FRAME_LEN
   );

endmodule

//--- hw/eth_dma_read.sv
`timescale 1ns/1ps

module eth_dma_read #(
   parameter int AXI_ADDR_W = 32,
   parameter int BUF_ADDR_W = 9
) (
   input  logic                   clk,
   input  logic                   rst,
   input  eth_dma_pkg::dma_cfg_t  cfg,
   input  logic                   run,
   output logic                   ready,
   output eth_dma_pkg::axi_ar_t   ar,
   output logic                   arvalid,
   input  logic                   arready,
   input  eth_dma_pkg::axi_r_t    r,
   input  logic                   rvalid,
   output logic                   rready,
   output eth_dma_pkg::buf_wr_t   buf_wr
);
   import eth_dma_pkg::*;

   dma_state_e              state;
   logic [AXI_ADDR_MAX-1:0] ar_addr;
   logic [7:0]              ar_len;
   logic [7:0]              burst_len;
   logic [DATA_W-1:0]       aligned;
   logic                    first_valid;
   logic                    did_first;
   logic                    transfer;
   logic                    flush;
   logic                    flush_wr;
   logic [LEN_W:0]          len_up;
   logic [8:0]              words;
   logic                    wr;
   logic [BUF_ADDR_W-1:0]   wr_addr;

   assign transfer = rvalid & rready;
   assign flush    = (state == FLUSH);

   // frame words = ceil(len / 4)
   assign len_up = {1'b0, cfg.len} + (LEN_W+1)'(3);
   assign words  = len_up[LEN_W:2];

   // with an offset the beats give one word fewer, unless the burst has a spare beat
   assign flush_wr = (cfg.addr[1:0] != 2'd0) && ({1'b0, burst_len} + 9'd1 == words);

   assign ar = '{addr: ar_addr, len: ar_len, size: AR_SIZE_WORD, burst: AR_BURST_INCR};

   assign buf_wr = '{wr: wr, addr: BUF_ADDR_MAX'(wr_addr), data: aligned};

   eth_burst_align u_align (
      .clk         (clk),
      .rst         (rst),
      .data        (r.data),
      .transfer    (transfer),
      .flush       (flush),
      .offset      (cfg.addr[1:0]),
      .len         (cfg.len),
      .burst_len   (burst_len),
      .data_out    (aligned),
      .first_valid (first_valid)
   );

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= IDLE;
         ready     <= 1'b1;
         arvalid   <= 1'b0;
         rready    <= 1'b0;
         ar_addr   <= '0;
         ar_len    <= '0;
         did_first <= 1'b0;
         wr        <= 1'b0;
         wr_addr   <= '0;
      end else begin
         wr <= 1'b0;
         case (state)
            IDLE: begin
               if (run) begin
                  ready     <= 1'b0;
                  arvalid   <= 1'b1;
                  ar_addr   <= AXI_ADDR_MAX'({cfg.addr[AXI_ADDR_W-1:2], 2'b00});
                  ar_len    <= burst_len;
                  did_first <= 1'b0;
                  wr_addr   <= BUF_ADDR_W'(TX_DATA_BASE - 1);   // pre-incremented
                  state     <= ADDR;
               end
            end
            ADDR: begin
               if (arready) begin
                  arvalid <= 1'b0;
                  rready  <= 1'b1;
                  state   <= DATA;
               end
            end
            DATA: begin
               if (transfer) begin
                  did_first <= 1'b1;
                  // first beat only primes the aligner when unaligned
                  if (first_valid || did_first) begin
                     wr      <= 1'b1;
                     wr_addr <= wr_addr + 1'b1;
                  end
                  if (r.last) begin
                     rready <= 1'b0;
                     state  <= FLUSH;
                  end
               end
            end
            FLUSH: begin
               if (flush_wr) begin
                  wr      <= 1'b1;
                  wr_addr <= wr_addr + 1'b1;
               end
               ready <= 1'b1;
               state <= FINISH;
            end
            FINISH: state <= IDLE;    // flushed word lands this cycle
            default: state <= IDLE;
         endcase
      end
   end

   ar_held_until_ready: assert property (
      @(posedge clk) disable iff (rst)
      arvalid && !arready |=> arvalid && $stable(ar)
   );

   rready_only_in_data: assert property (
      @(posedge clk) disable iff (rst) rready |-> state == DATA
   );

endmodule

//--- hw/eth_tx_buffer.sv
`timescale 1ns/1ps

module eth_tx_buffer #(
   parameter int BUF_ADDR_W = 9
) (
   input  logic                           clk,
   input  eth_dma_pkg::buf_wr_t           wr,
   input  logic [BUF_ADDR_W-1:0]          rd_addr,
   output logic [eth_dma_pkg::DATA_W-1:0] rd_data
);
   import eth_dma_pkg::*;

   logic [DATA_W-1:0] mem [2**BUF_ADDR_W];

   // write port from the DMA
   always_ff @(posedge clk) begin
      if (wr.wr)
         mem[wr.addr[BUF_ADDR_W-1:0]] <= wr.data;
   end

   // registered read, data one cycle after address
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

//--- hw/eth_dma_top.sv
`timescale 1ns/1ps

module eth_dma_top #(
   parameter int AXI_ADDR_W = 32,
   parameter int BUF_ADDR_W = 9
) (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           cfg_wr,
   input  logic                           cfg_rd,
   input  eth_dma_pkg::cfg_reg_e          cfg_sel,
   input  logic [31:0]                    cfg_wdata,
   output logic [31:0]                    cfg_rdata,
   output eth_dma_pkg::axi_ar_t           m_axi_ar,
   output logic [3:0]                     m_axi_arcache,
   output logic [2:0]                     m_axi_arprot,
   output logic                           m_axi_arlock,
   output logic [3:0]                     m_axi_arqos,
   output logic                           m_axi_arid,
   output logic                           m_axi_arvalid,
   input  logic                           m_axi_arready,
   input  eth_dma_pkg::axi_r_t            m_axi_r,
   input  logic                           m_axi_rvalid,
   output logic                           m_axi_rready,
   input  logic [BUF_ADDR_W-1:0]          buf_rd_addr,
   output logic [eth_dma_pkg::DATA_W-1:0] buf_rd_data
);
   import eth_dma_pkg::*;

   dma_cfg_t cfg;
   logic     run;
   logic     ready;
   buf_wr_t  buf_wr;

   // fixed AR sideband
   assign m_axi_arcache = AR_CACHE;
   assign m_axi_arprot  = AR_PROT;
   assign m_axi_arlock  = 1'b0;
   assign m_axi_arqos   = 4'd0;
   assign m_axi_arid    = 1'b0;

   eth_dma_regs #(
      .AXI_ADDR_W (AXI_ADDR_W)
   ) u_regs (
      .clk       (clk),
      .rst       (rst),
      .cfg_wr    (cfg_wr),
      .cfg_rd    (cfg_rd),
      .cfg_sel   (cfg_sel),
      .cfg_wdata (cfg_wdata),
      .cfg_rdata (cfg_rdata),
      .cfg       (cfg),
      .run       (run),
      .ready     (ready)
   );

   eth_dma_read #(
      .AXI_ADDR_W (AXI_ADDR_W),
      .BUF_ADDR_W (BUF_ADDR_W)
   ) u_read (
      .clk     (clk),
      .rst     (rst),
      .cfg     (cfg),
      .run     (run),
      .ready   (ready),
      .ar      (m_axi_ar),
      .arvalid (m_axi_arvalid),
      .arready (m_axi_arready),
      .r       (m_axi_r),
      .rvalid  (m_axi_rvalid),
      .rready  (m_axi_rready),
      .buf_wr  (buf_wr)
   );

   eth_tx_buffer #(
      .BUF_ADDR_W (BUF_ADDR_W)
   ) u_buf (
      .clk     (clk),
      .wr      (buf_wr),
      .rd_addr (buf_rd_addr),
      .rd_data (buf_rd_data)
   );

endmodule

//--- bench/tb_clk.sv
`timescale 1ns/1ps

module tb_clk #(
   parameter int HALF_PERIOD = 50   // ns, 100 ns clock
) (
   output logic clk
);

   initial clk = 1'b0;

   always #(HALF_PERIOD) clk = ~clk;

endmodule

//--- bench/axi_rd_mem.sv
`timescale 1ns/1ps

module axi_rd_mem #(
   parameter int IMG_WORDS = 32
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 gaps_on,
   input  logic [31:0]          image [IMG_WORDS],
   input  eth_dma_pkg::axi_ar_t ar,
   input  logic                 arvalid,
   output logic                 arready,
   output eth_dma_pkg::axi_r_t  r,
   output logic                 rvalid,
   input  logic                 rready,
   output eth_dma_pkg::axi_ar_t ar_seen,
   output int                   ar_count
);
   import eth_dma_pkg::*;

   logic        active;
   logic [29:0] word_idx;
   logic [8:0]  left;      // beats still to present

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         arready  <= 1'b0;
         rvalid   <= 1'b0;
         r        <= '0;
         active   <= 1'b0;
         word_idx <= '0;
         left     <= '0;
         ar_seen  <= '0;
         ar_count <= 0;
      end else begin
         arready <= gaps_on ? 1'($urandom % 2) : 1'b1;
         if (arvalid && arready) begin
            ar_seen  <= ar;          // fields checked by the testbench
            ar_count <= ar_count + 1;
            word_idx <= ar.addr[31:2];
            left     <= {1'b0, ar.len} + 9'd1;
            active   <= 1'b1;
         end
         if (rvalid && rready)
            rvalid <= 1'b0;
         if (active && (!rvalid || rready)) begin
            if (left == 9'd0) begin
               active <= 1'b0;
            end else if (!gaps_on || ($urandom % 4) != 0) begin
               rvalid   <= 1'b1;
               r        <= '{data: image[word_idx % IMG_WORDS], resp: 2'b00,
                             last: (left == 9'd1)};
               word_idx <= word_idx + 30'd1;
               left     <= left - 9'd1;
            end
         end
      end
   end

endmodule

//--- bench/eth_dma_tb.sv
`timescale 1ns/1ps

module eth_dma_tb;
   import eth_dma_pkg::*;

   localparam int BUF_ADDR_W = 9;
   localparam int IMG_WORDS  = 32;
   localparam int IMG_BASE   = 16;    // image starts at file word 0x10
   localparam int MAX_JOBS   = 7;
   localparam int POLL_LIMIT = 100;

   logic                  clk;
   logic                  rst;
   logic                  cfg_wr;
   logic                  cfg_rd;
   cfg_reg_e              cfg_sel;
   logic [31:0]           cfg_wdata;
   logic [31:0]           cfg_rdata;
   axi_ar_t               ar;
   logic [3:0]            arcache;
   logic [2:0]            arprot;
   logic                  arlock;
   logic [3:0]            arqos;
   logic                  arid;
   logic                  arvalid;
   logic                  arready;
   axi_r_t                r;
   logic                  rvalid;
   logic                  rready;
   logic [BUF_ADDR_W-1:0] buf_rd_addr;
   logic [DATA_W-1:0]     buf_rd_data;
   logic                  gaps_on;
   axi_ar_t               ar_seen;
   int                    ar_count;
   logic [31:0]           file_words [48];
   logic [31:0]           image [IMG_WORDS];

   tb_clk u_clk (.clk(clk));

   axi_rd_mem #(.IMG_WORDS(IMG_WORDS)) u_mem (
      .clk(clk), .rst(rst), .gaps_on(gaps_on), .image(image),
      .ar(ar), .arvalid(arvalid), .arready(arready),
      .r(r), .rvalid(rvalid), .rready(rready),
      .ar_seen(ar_seen), .ar_count(ar_count)
   );

   eth_dma_top #(.AXI_ADDR_W(32), .BUF_ADDR_W(BUF_ADDR_W)) DUT (
      .clk(clk), .rst(rst), .cfg_wr(cfg_wr), .cfg_rd(cfg_rd), .cfg_sel(cfg_sel),
      .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
      .m_axi_ar(ar), .m_axi_arcache(arcache), .m_axi_arprot(arprot),
      .m_axi_arlock(arlock), .m_axi_arqos(arqos), .m_axi_arid(arid),
      .m_axi_arvalid(arvalid), .m_axi_arready(arready),
      .m_axi_r(r), .m_axi_rvalid(rvalid), .m_axi_rready(rready),
      .buf_rd_addr(buf_rd_addr), .buf_rd_data(buf_rd_data)
   );

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
      if (got !== exp)
         abort_run($sformatf("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp));
   endtask

   task automatic check_status(input string name, input dma_status_t got,
                               input dma_status_t exp);
      if (got !== exp)
         abort_run($sformatf("ERROR at %0t: %s is ready %b done %b, expected ready %b done %b",
                             $time, name, got.ready, got.done, exp.ready, exp.done));
   endtask

   task automatic check_ar(input string name, input axi_ar_t got, input axi_ar_t exp);
      if (got !== exp)
         abort_run($sformatf(
            "ERROR at %0t: %s (addr len size burst) is %h %0d %0d %0d, expected %h %0d %0d %0d",
            $time, name, got.addr, got.len, got.size, got.burst,
            exp.addr, exp.len, exp.size, exp.burst));
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         abort_run($sformatf("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp));
   endtask

   task automatic check_field(input string name, input logic [3:0] got, input logic [3:0] exp);
      if (got !== exp)
         abort_run($sformatf("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp));
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp)
         abort_run($sformatf("ERROR at %0t: %s is %0d, expected %0d", $time, name, got, exp));
   endtask

   // bus stays driven until the next access
   task automatic write_reg(input cfg_reg_e sel, input logic [31:0] data);
      @(posedge clk);
      cfg_wr    <= 1'b1;
      cfg_rd    <= 1'b0;
      cfg_sel   <= sel;
      cfg_wdata <= data;
   endtask

   task automatic read_reg(input cfg_reg_e sel, output logic [31:0] data);
      @(posedge clk);
      cfg_wr  <= 1'b0;
      cfg_rd  <= 1'b1;
      cfg_sel <= sel;
      @(posedge clk);
      cfg_rd <= 1'b0;
      @(negedge clk);
      data = cfg_rdata;
   endtask

   task automatic read_buf(input logic [BUF_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
      @(posedge clk);
      buf_rd_addr <= addr;
      @(posedge clk);
      @(negedge clk);
      data = buf_rd_data;
   endtask

   // little endian byte view of the memory image
   function automatic logic [7:0] mem_byte(input int a);
      logic [31:0] w;
      w = image[(a / 4) % IMG_WORDS];
      return w[8*(a % 4) +: 8];
   endfunction

   task automatic run_job(input logic [31:0] addr, input int len);
      logic [31:0]       rdata;
      logic [DATA_W-1:0] got;
      logic [DATA_W-1:0] exp;
      logic [DATA_W-1:0] mask;
      axi_ar_t           exp_ar;
      int                count_before;
      int                beats;
      int                polls;
      int                k;
      int                i;

      count_before = ar_count;
      beats  = (int'(addr[1:0]) + len + 3) / 4;
      exp_ar = '{addr: {addr[31:2], 2'b00}, len: 8'(beats - 1), size: 3'd2, burst: 2'b01};

      write_reg(REG_ADDR, addr);
      write_reg(REG_LEN, 32'(len));
      write_reg(REG_CTRL, 32'd1);
      write_reg(REG_CTRL, 32'd1);   // lands on the run pulse
      write_reg(REG_CTRL, 32'd1);   // lands while busy
      read_reg(REG_STATUS, rdata);
      check_status("status while busy", dma_status_t'(rdata[1:0]),
                   dma_status_t'{ready: 1'b0, done: 1'b0});

      polls = 0;
      do begin
         read_reg(REG_STATUS, rdata);
         polls++;
         if (polls > POLL_LIMIT)
            abort_run($sformatf("timeout: done not set after %0d status reads", POLL_LIMIT));
      end while (rdata[0] !== 1'b1);
      check_status("status after done", dma_status_t'(rdata[1:0]),
                   dma_status_t'{ready: 1'b1, done: 1'b1});
      check_count("AR bursts per run", ar_count - count_before, 1);
      check_ar("m_axi_ar", ar_seen, exp_ar);
      check_field("m_axi_arcache", arcache, 4'd2);
      check_field("m_axi_arprot", 4'(arprot), 4'd2);
      check_bit("m_axi_arlock", arlock, 1'b0);
      check_field("m_axi_arqos", arqos, 4'd0);
      check_bit("m_axi_arid", arid, 1'b0);

      read_reg(REG_ADDR, rdata);
      check_word("cfg_rdata REG_ADDR", rdata, addr);
      read_reg(REG_LEN, rdata);
      check_word("cfg_rdata REG_LEN", rdata, 32'(len));

      for (k = 0; k < (len + 3) / 4; k++) begin
         exp  = '0;
         mask = '0;
         for (i = 0; i < 4; i++) begin
            if (4*k + i < len) begin        // bytes past the frame are not compared
               exp[8*i +: 8]  = mem_byte(int'(addr) + 4*k + i);
               mask[8*i +: 8] = 8'hff;
            end
         end
         read_buf(BUF_ADDR_W'(TX_DATA_BASE + k), got);
         check_word($sformatf("buf_rd_data[%0d]", TX_DATA_BASE + k), got & mask, exp);
      end
   endtask

   initial begin
      logic [31:0] rdata;
      int          seed;
      int          njobs;
      int          npass;
      int          pass;
      int          j;

      rst         = 1'b1;
      cfg_wr      = 1'b0;
      cfg_rd      = 1'b0;
      cfg_sel     = REG_ADDR;
      cfg_wdata   = '0;
      buf_rd_addr = '0;
      gaps_on     = 1'b0;
      seed        = $urandom(72);

      $readmemh("bench/dma_input.txt", file_words);
      for (j = 0; j < IMG_WORDS; j++)
         image[j] = file_words[IMG_BASE + j];
      njobs = int'(file_words[1]);
      npass = (file_words[0][0] === 1'b1) ? 2 : 1;   // second pass with gaps
      if (njobs < 1 || njobs > MAX_JOBS)
         abort_run("bench/dma_input.txt holds no valid job count");

      repeat (16) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_bit("m_axi_arvalid", arvalid, 1'b0);
      check_bit("m_axi_rready", rready, 1'b0);
      read_reg(REG_STATUS, rdata);
      check_status("status after reset", dma_status_t'(rdata[1:0]),
                   dma_status_t'{ready: 1'b1, done: 1'b0});

      for (pass = 0; pass < npass; pass++) begin
         @(posedge clk);
         gaps_on <= (pass == 1);
         for (j = 0; j < njobs; j++)
            run_job(file_words[2 + 2*j], int'(file_words[3 + 2*j]));
      end

      $display("sim passed");
      $finish;
   end

endmodule

//--- bench/dma_input.txt
// word 0 gap enable, word 1 job count, words 2 on: job byte address and byte length
// words 0x10 on: memory image, 32-bit words from byte address 0, lowest byte first
@0
00000001 00000007
00000000 00000010
00000011 0000000D
00000022 0000000A
00000033 00000007
00000041 00000003
00000006 0000001E
00000048 00000015
@10
13121110 17161514 1B1A1918 1F1E1D1C
23222120 27262524 2B2A2928 2F2E2D2C
33323130 37363534 3B3A3938 3F3E3D3C
43424140 47464544 4B4A4948 4F4E4D4C
53525150 57565554 5B5A5958 5F5E5D5C
63626160 67666564 6B6A6968 6F6E6D6C
73727170 77767574 7B7A7978 7F7E7D7C
83828180 87868584 8B8A8988 8F8E8D8C

//--- list.f
hw/eth_dma_pkg.sv
hw/eth_dma_regs.sv
hw/eth_burst_align.sv
hw/eth_dma_read.sv
hw/eth_tx_buffer.sv
hw/eth_dma_top.sv
bench/tb_clk.sv
bench/axi_rd_mem.sv
bench/eth_dma_tb.sv

//--- run.sh
#!/bin/sh
# build and run the DMA testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module eth_dma_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/Veth_dma_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
   exit 0
fi
echo "pass line not found in simulation output"
exit 1
